//--- bench/riscv_v_sign_unit_tb.sv
// ======================================================================
// Testbench for the vector sign unit. Drives LFSR stimulus at every
// element width and op, and checks results with concurrent assertions
// against a per-element arithmetic model held in an expected queue.
// ======================================================================

module riscv_v_sign_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import riscv_v_pkg::*;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic [1:0]  sew;
    logic [1:0]  op;
    logic [7:0]  mask;
    logic [63:0] in_data;
    logic        out_valid;
    logic [63:0] out_data;
    logic [7:0]  ovf;

    logic [63:0] exp_data_q[$];
    logic [7:0]  exp_ovf_q[$];
    logic [63:0] head_data = '0;
    logic [7:0]  head_ovf = '0;
    logic [31:0] lfsr_state = 32'h5c3b3b0c;
    int          errors = 0;
    int          errors_at_start = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    riscv_v_sign_unit dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .sew       (sew),
        .op        (op),
        .mask      (mask),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .ovf       (ovf)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [63:0] next_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[62:0], fb};
        end
        return v;
    endfunction

    // One element of width w, arithmetic negate when the op asks for it
    function automatic logic [63:0] elem_calc(input logic [63:0] v, input int w,
                                              input logic [1:0] opc, input logic act,
                                              output logic flag);
        logic [63:0] wmask;
        logic        sgn;
        logic        comp;
        wmask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        sgn   = v[w-1];
        comp  = act && (opc == OP_NEG || (opc == OP_ABS && sgn) || (opc == OP_NABS && !sgn));
        flag  = comp && (v == (64'd1 << (w - 1)));
        return comp ? ((64'd0 - v) & wmask) : v;
    endfunction

    function automatic void calc_expected(input logic [63:0] din, input logic [1:0] s,
                                          input logic [1:0] opc, input logic [7:0] m,
                                          output logic [63:0] dout, output logic [7:0] fl);
        riscv_v_data_u a;
        riscv_v_data_u r;
        logic          f;
        a  = din;
        r  = din;
        fl = '0;
        for (int i = 0; i < (8 >> s); i++) begin
            f = 1'b0;
            case (s)
                SEW_8:  r.bytes[i]  = 8'(elem_calc(64'(a.bytes[i]), 8, opc, m[i], f));
                SEW_16: r.halves[i] = 16'(elem_calc(64'(a.halves[i]), 16, opc, m[i], f));
                SEW_32: r.words[i]  = 32'(elem_calc(64'(a.words[i]), 32, opc, m[i], f));
                default: r.dword    = elem_calc(a.dword, 64, opc, m[i], f);
            endcase
            fl[i] = f;
        end
        dout = r;
    endfunction

    // Overwrite selected elements with the most negative value
    function automatic logic [63:0] plant_min(input logic [1:0] s, input logic [7:0] sel,
                                              input logic [63:0] base);
        logic [63:0] d;
        int          w;
        d = base;
        w = 8 << s;
        for (int i = 0; i < (8 >> s); i++) begin
            if (sel[i]) begin
                for (int j = 0; j < w; j++) begin
                    d[i*w + j] = (j == w - 1);
                end
            end
        end
        return d;
    endfunction

    task automatic apply(input logic [1:0] s, input logic [1:0] opc,
                         input logic [7:0] m, input logic [63:0] d);
        logic [63:0] ed;
        logic [7:0]  ef;
        calc_expected(d, s, opc, m, ed, ef);
        in_valid = 1'b1;
        sew      = s;
        op       = opc;
        mask     = m;
        in_data  = d;
        exp_data_q.push_back(ed);
        exp_ovf_q.push_back(ef);
        @(posedge clk);
        #5;
    endtask

    task automatic apply_random();
        apply(2'(next_bits(2)), 2'(next_bits(2)), 8'(next_bits(8)), next_bits(64));
    endtask

    task automatic idle(input int cycles);
        in_valid = 1'b0;
        repeat (cycles) begin
            // Inputs that would flag every element must not reach the outputs
            op      = OP_NEG;
            mask    = 8'hff;
            in_data = plant_min(sew, 8'hff, 64'd0);
            @(posedge clk);
            #5;
        end
    endtask

    // Drain outstanding results, then report the test
    task automatic end_test(input string name);
        int n;
        in_valid = 1'b0;
        n = 0;
        while (exp_data_q.size() != 0 && n < 20) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (exp_data_q.size() != 0) begin
            $display("Timeout in %s: %0d results never came out", name, exp_data_q.size());
            errors++;
            exp_data_q.delete();
            exp_ovf_q.delete();
        end
        if (errors == errors_at_start) begin
            pass_cnt++;
            $display("%-10s : ok", name);
        end else begin
            fail_cnt++;
            $display("%-10s : %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // Queue head for the result now on the outputs
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("Error at %0t: out_valid high with no word outstanding", $time);
                errors++;
            end else begin
                head_data = exp_data_q.pop_front();
                head_ovf  = exp_ovf_q.pop_front();
            end
        end
    end

    assert property (@(posedge clk) (!arst_n || !$past(arst_n)) |->
                     (!out_valid && out_data == '0 && ovf == '0))
        else begin
            $display("FAIL %0t: outputs not cleared around reset", $time);
            errors++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> out_data == head_data)
        else begin
            $display("FAIL %0t: out_data %h, expected %h", $time, $sampled(out_data), head_data);
            errors++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> ovf == head_ovf)
        else begin
            $display("FAIL %0t: ovf %b, expected %b", $time, $sampled(ovf), head_ovf);
            errors++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) out_valid == $past(in_valid))
        else begin
            $display("FAIL %0t: out_valid does not follow in_valid", $time);
            errors++;
        end

    // Outputs hold through a gap
    assert property (@(posedge clk) disable iff (!arst_n)
                     !$past(in_valid) |-> ($stable(out_data) && $stable(ovf)))
        else begin
            $display("FAIL %0t: outputs changed while in_valid was low", $time);
            errors++;
        end

    initial begin
        arst_n   = 1'b0;
        in_valid = 1'b0;
        sew      = SEW_8;
        op       = OP_PASS;
        mask     = '0;
        in_data  = '0;
        repeat (4) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(posedge clk);
        #5;
        end_test("reset");

        for (int s = 0; s < 4; s++) begin
            repeat (8) apply(2'(s), OP_NEG, 8'hff, next_bits(64));
        end
        end_test("negate");

        for (int s = 0; s < 4; s++) begin
            repeat (8) apply(2'(s), OP_ABS, 8'hff, next_bits(64));
            repeat (8) apply(2'(s), OP_NABS, 8'hff, next_bits(64));
        end
        end_test("abs_nabs");

        for (int s = 0; s < 4; s++) begin
            repeat (8) apply(2'(s), OP_NEG, 8'(next_bits(8)), next_bits(64));
            repeat (4) apply(2'(s), OP_PASS, 8'(next_bits(8)), next_bits(64));
            // Zero elements beside masked-off ones would expose a leaking carry
            apply(2'(s), OP_NEG, 8'h55, 64'h0);
        end
        end_test("mask_pass");

        // Most negative elements under each op, full and random masks
        for (int s = 0; s < 4; s++) begin
            repeat (4) begin
                apply(2'(s), OP_NEG, 8'hff, plant_min(2'(s), 8'(next_bits(8)), next_bits(64)));
                apply(2'(s), OP_ABS, 8'hff, plant_min(2'(s), 8'(next_bits(8)), next_bits(64)));
                apply(2'(s), OP_NABS, 8'hff, plant_min(2'(s), 8'hff, next_bits(64)));
                apply(2'(s), OP_NEG, 8'(next_bits(8)), plant_min(2'(s), 8'hff, next_bits(64)));
            end
        end
        end_test("overflow");

        repeat (200) apply_random();
        repeat (6) begin
            idle(int'(next_bits(2)) + 1);
            repeat (5) apply_random();
        end
        end_test("streaming");

        $display("Summary: %0d tests ok, %0d tests with errors, %0d check errors",
                 pass_cnt, fail_cnt, errors);
        if (errors == 0 && fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : riscv_v_sign_unit_tb

//--- design/adder_nbit.sv
// ====================================================================
// Generic N-bit adder with carry in and carry out. ADDER_TYPE picks
// a single behavioral sum or an explicit ripple chain of bit cells.
// ====================================================================

module adder_nbit #(
    parameter int WIDTH      = 8,
    parameter     ADDER_TYPE = "BEHAVIORAL_ADDER"
) (
    input  logic [WIDTH-1:0] A,
    input  logic [WIDTH-1:0] B,
    input  logic             cin,
    output logic [WIDTH-1:0] S,
    output logic             cout
);

    generate
        if (ADDER_TYPE == "BEHAVIORAL_ADDER") begin : gen_behav
            assign {cout, S} = A + B + WIDTH'(cin);
        end else begin : gen_ripple
            logic [WIDTH:0] carry;

            assign carry[0] = cin;

            // One full adder per bit
            for (genvar i = 0; i < WIDTH; i++) begin : gen_bit
                assign S[i]       = A[i] ^ B[i] ^ carry[i];
                assign carry[i+1] = (A[i] & B[i]) | (carry[i] & (A[i] ^ B[i]));
            end

            assign cout = carry[WIDTH];
        end
    endgenerate

endmodule : adder_nbit

//--- design/riscv_v_elem_ctrl.sv
// ====================================================================
// Element control for the sign unit. Decides per element whether to
// complement, builds the carry merge pattern and one-hot width, and
// flags overflow when the most negative value would be negated.
// ====================================================================

module riscv_v_elem_ctrl (
    input  logic [1:0]                                       sew,
    input  logic [1:0]                                       op,
    input  logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0]   mask,
    input  riscv_v_pkg::riscv_v_data_u                       data,
    output logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0]   complement,
    output logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0]   merge,
    output logic [riscv_v_pkg::RISCV_V_NUM_VALID_OSIZES-1:0] osize_vector,
    output logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0]   ovf
);

    import riscv_v_pkg::*;

    // Per element, indexed by element number
    logic [RISCV_V_NUM_BYTES_DATA-1:0] sign_bit;
    logic [RISCV_V_NUM_BYTES_DATA-1:0] min_neg;
    logic [RISCV_V_NUM_BYTES_DATA-1:0] elem_comp;

    function automatic logic needs_comp(input logic [1:0] opc, input logic sgn);
        case (opc)
            OP_PASS: return 1'b0;
            OP_NEG:  return 1'b1;
            OP_ABS:  return sgn;
            OP_NABS: return ~sgn;
            default: return 1'b0;
        endcase
    endfunction

    // Sign and most-negative test through the matching view
    always_comb begin
        sign_bit = '0;
        min_neg  = '0;
        case (sew)
            SEW_8: begin
                for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
                    sign_bit[i] = data.bytes[i][BYTE_WIDTH-1];
                    min_neg[i]  = (data.bytes[i] == {1'b1, {(BYTE_WIDTH-1){1'b0}}});
                end
            end
            SEW_16: begin
                for (int i = 0; i < RISCV_V_NUM_HALVES; i++) begin
                    sign_bit[i] = data.halves[i][RISCV_V_HALF_WIDTH-1];
                    min_neg[i]  = (data.halves[i] == {1'b1, {(RISCV_V_HALF_WIDTH-1){1'b0}}});
                end
            end
            SEW_32: begin
                for (int i = 0; i < RISCV_V_NUM_WORDS; i++) begin
                    sign_bit[i] = data.words[i][RISCV_V_WORD_WIDTH-1];
                    min_neg[i]  = (data.words[i] == {1'b1, {(RISCV_V_WORD_WIDTH-1){1'b0}}});
                end
            end
            SEW_64: begin
                sign_bit[0] = data.dword[RISCV_V_DATA_WIDTH-1];
                min_neg[0]  = (data.dword == {1'b1, {(RISCV_V_DATA_WIDTH-1){1'b0}}});
            end
            default: ;
        endcase
    end

    // Complement bit lands on the element's base byte only
    always_comb begin
        elem_comp  = '0;
        complement = '0;
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            if (i < (RISCV_V_NUM_BYTES_DATA >> sew)) begin
                elem_comp[i]        = mask[i] & needs_comp(op, sign_bit[i]);
                complement[i << sew] = elem_comp[i];
            end
        end
    end

    assign ovf = elem_comp & min_neg;

    // Bytes k and k+1 share an element unless k+1 starts a new one
    always_comb begin
        for (int k = 0; k < RISCV_V_NUM_BYTES_DATA; k++) begin
            merge[k] = (((k + 1) & ((1 << sew) - 1)) != 0);
        end
    end

    assign osize_vector = RISCV_V_NUM_VALID_OSIZES'(1) << sew;

endmodule : riscv_v_elem_ctrl

//--- design/riscv_v_pkg.sv
// ====================================================================
// Shared widths, element-width and operation codes for the vector
// sign-handling datapath. Modules import this package inside their
// bodies and use scoped names in their port lists.
// ====================================================================

package riscv_v_pkg;

    // Basic widths
    localparam int BYTE_WIDTH               = 8;
    localparam int RISCV_V_DATA_WIDTH       = 64;
    localparam int RISCV_V_HALF_WIDTH       = 2 * BYTE_WIDTH;
    localparam int RISCV_V_WORD_WIDTH       = 4 * BYTE_WIDTH;
    localparam int RISCV_V_NUM_BYTES_DATA   = RISCV_V_DATA_WIDTH / BYTE_WIDTH;
    localparam int RISCV_V_NUM_VALID_OSIZES = 4;

    // Element counts per width
    localparam int RISCV_V_NUM_HALVES = RISCV_V_DATA_WIDTH / RISCV_V_HALF_WIDTH;
    localparam int RISCV_V_NUM_WORDS  = RISCV_V_DATA_WIDTH / RISCV_V_WORD_WIDTH;

    // Element width codes, value is log2 of element size in bytes
    localparam logic [1:0] SEW_8  = 2'd0;
    localparam logic [1:0] SEW_16 = 2'd1;
    localparam logic [1:0] SEW_32 = 2'd2;
    localparam logic [1:0] SEW_64 = 2'd3;

    // Sign operations
    localparam logic [1:0] OP_PASS = 2'd0;
    localparam logic [1:0] OP_NEG  = 2'd1;
    localparam logic [1:0] OP_ABS  = 2'd2;
    localparam logic [1:0] OP_NABS = 2'd3;

    // One vector word, viewed at each element width
    typedef union packed {
        logic [RISCV_V_NUM_BYTES_DATA-1:0][BYTE_WIDTH-1:0] bytes;
        logic [RISCV_V_NUM_HALVES-1:0][RISCV_V_HALF_WIDTH-1:0] halves;
        logic [RISCV_V_NUM_WORDS-1:0][RISCV_V_WORD_WIDTH-1:0] words;
        logic [RISCV_V_DATA_WIDTH-1:0] dword;
    } riscv_v_data_u;

endpackage : riscv_v_pkg

//--- design/riscv_v_sign_unit.sv
// ====================================================================
// Top level of the vector sign unit. Applies pass, negate, abs or
// negated abs per element and registers the result with one cycle
// of latency and a plain valid strobe.
// ====================================================================

module riscv_v_sign_unit (
    input  logic                                           clk,
    input  logic                                           arst_n,
    input  logic                                           in_valid,
    input  logic [1:0]                                     sew,
    input  logic [1:0]                                     op,
    input  logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0] mask,
    input  logic [riscv_v_pkg::RISCV_V_DATA_WIDTH-1:0]     in_data,
    output logic                                           out_valid,
    output logic [riscv_v_pkg::RISCV_V_DATA_WIDTH-1:0]     out_data,
    output logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0] ovf
);

    import riscv_v_pkg::*;

    riscv_v_data_u                     in_word;
    logic [RISCV_V_NUM_BYTES_DATA-1:0] complement;
    logic [RISCV_V_NUM_BYTES_DATA-1:0] merge;
    logic [RISCV_V_NUM_VALID_OSIZES-1:0] osize_vector;
    logic [RISCV_V_NUM_BYTES_DATA-1:0] ovf_comb;
    logic [RISCV_V_DATA_WIDTH-1:0]     result;

    assign in_word = in_data;

    riscv_v_elem_ctrl u_ctrl (
        .sew          (sew),
        .op           (op),
        .mask         (mask),
        .data         (in_word),
        .complement   (complement),
        .merge        (merge),
        .osize_vector (osize_vector),
        .ovf          (ovf_comb)
    );

    riscv_v_twos_comp_sel #(
        .BLOCK_WIDTH (BYTE_WIDTH)
    ) u_sel (
        .in           (in_data),
        .complement   (complement),
        .osize_vector (osize_vector),
        .merge        (merge),
        .out          (result)
    );

    // Result holds its value through gaps in in_valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            ovf       <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_data <= result;
                ovf      <= ovf_comb;
            end
        end
    end

endmodule : riscv_v_sign_unit

//--- design/riscv_v_twos_comp_sel.sv
// ====================================================================
// Conditional two's complement over a vector word. Each byte block is
// inverted and incremented through its own adder, and carries chain
// between blocks only where merge marks them as one element.
// ====================================================================

module riscv_v_twos_comp_sel #(
    parameter int BLOCK_WIDTH = riscv_v_pkg::BYTE_WIDTH
) (
    input  logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0][BLOCK_WIDTH-1:0] in,
    input  logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0]                  complement,
    input  logic [riscv_v_pkg::RISCV_V_NUM_VALID_OSIZES-1:0]                osize_vector,
    input  logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0]                  merge,
    output logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0][BLOCK_WIDTH-1:0] out
);

    import riscv_v_pkg::*;

    // Complement bit spread over each element, one copy per width
    logic [RISCV_V_NUM_VALID_OSIZES-1:0][RISCV_V_NUM_BYTES_DATA-1:0] comp_by_size;
    logic [RISCV_V_NUM_BYTES_DATA-1:0]                               comp_ext;

    logic [RISCV_V_NUM_BYTES_DATA-1:0][BLOCK_WIDTH-1:0] in_xor;
    logic [RISCV_V_NUM_BYTES_DATA-1:0]                  carry_in;
    logic [RISCV_V_NUM_BYTES_DATA-1:0]                  carry_out;

    generate
        for (genvar s = 0; s < RISCV_V_NUM_VALID_OSIZES; s++) begin : gen_size
            localparam int SPAN = 2 ** s;

            // Base byte of each element drives all its bytes
            for (genvar e = 0; e < RISCV_V_NUM_BYTES_DATA / SPAN; e++) begin : gen_elem
                assign comp_by_size[s][e*SPAN +: SPAN] = {SPAN{complement[e*SPAN]}};
            end
        end
    endgenerate

    // Keep only the copy for the active element width
    always_comb begin
        comp_ext = '0;
        for (int s = 0; s < RISCV_V_NUM_VALID_OSIZES; s++) begin
            comp_ext |= comp_by_size[s] & {RISCV_V_NUM_BYTES_DATA{osize_vector[s]}};
        end
    end

    // The increment enters at the base byte and ripples up inside the element
    assign carry_in[0] = complement[0];

    generate
        for (genvar k = 1; k < RISCV_V_NUM_BYTES_DATA; k++) begin : gen_carry
            assign carry_in[k] = complement[k] | (carry_out[k-1] & merge[k-1]);
        end
    endgenerate

    generate
        for (genvar b = 0; b < RISCV_V_NUM_BYTES_DATA; b++) begin : gen_block
            assign in_xor[b] = in[b] ^ {BLOCK_WIDTH{comp_ext[b]}};

            adder_nbit #(
                .WIDTH      (BLOCK_WIDTH),
                .ADDER_TYPE ("BEHAVIORAL_ADDER")
            ) u_adder (
                .A    (in_xor[b]),
                .B    ('0),
                .cin  (carry_in[b]),
                .S    (out[b]),
                .cout (carry_out[b])
            );
        end
    endgenerate

endmodule : riscv_v_twos_comp_sel

//--- riscv_v_sign_unit.f
design/riscv_v_pkg.sv
design/adder_nbit.sv
design/riscv_v_twos_comp_sel.sv
design/riscv_v_elem_ctrl.sv
design/riscv_v_sign_unit.sv
bench/riscv_v_sign_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sign unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module riscv_v_sign_unit_tb \
    -f riscv_v_sign_unit.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
